// File: life_matrix.f
source/life_pkg.sv
source/scan_pkg.sv
source/frame_timer.sv
source/board_state.sv
source/life_cell.sv
source/matrix_scanner.sv
source/life_matrix.sv
verif/life_matrix_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the life_matrix testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module life_matrix_tb -f life_matrix.f \
    -Mdir "$BUILD_DIR" -o life_matrix_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/life_matrix_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0

// File: source/board_state.sv
`default_nettype none

module board_state (
    input  logic             clk,
    input  logic             reset,
    // external seed load
    input  logic             seed_valid,
    input  life_pkg::board_t seed,
    // generation strobe from the timer
    input  logic             step_tick,
    // next generation from the cell array
    input  life_pkg::board_t next_board,
    output life_pkg::board_t board,
    output logic             step
);

    // step is dropped when a seed load wins
    logic step_taken;

    assign step_taken = step_tick && !seed_valid;

    // generation register
    // priority is reset, then seed, then step
    always_ff @(posedge clk) begin
        if (reset) begin
            board <= life_pkg::default_seed;
        end else if (seed_valid) begin
            board <= seed;
        end else if (step_tick) begin
            board <= next_board;
        end
    end

    // step marks the first cycle of the new board
    // one cycle behind step_tick
    always_ff @(posedge clk) begin
        if (reset) begin
            step <= 1'b0;
        end else begin
            step <= step_taken;
        end
    end

    // a seed strobe always shows up on the board next cycle
    // even when a step strobe arrives with it
    seed_loads_board : assert property (
        @(posedge clk) (seed_valid && !reset) |=> (board == $past(seed))
    );

endmodule

`default_nettype wire

// File: source/frame_timer.sv
`default_nettype none

module frame_timer #(
    // clock cycles between scan ticks
    parameter int SCAN_CYCLES = 1000,
    // clock cycles between generation steps
    parameter int STEP_CYCLES = 1000000
) (
    input  logic clk,
    input  logic reset,
    output logic scan_tick,
    output logic step_tick
);

    // counter widths, at least one bit each
    localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
    localparam int STEP_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    // terminal counts
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_CYCLES - 1);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(STEP_CYCLES - 1);

    logic [SCAN_W-1:0] scan_count;
    logic [STEP_W-1:0] step_count;

    // row scan divider
    // count runs 0 .. SCAN_LAST, tick comes out on the wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_count <= '0;
            scan_tick  <= 1'b0;
        end else if (scan_count == SCAN_LAST) begin
            scan_count <= '0;
            scan_tick  <= 1'b1;
        end else begin
            scan_count <= scan_count + 1'b1;
            scan_tick  <= 1'b0;
        end
    end

    // generation divider
    // first step_tick lands STEP_CYCLES cycles after reset drops
    always_ff @(posedge clk) begin
        if (reset) begin
            step_count <= '0;
            step_tick  <= 1'b0;
        end else if (step_count == STEP_LAST) begin
            step_count <= '0;
            step_tick  <= 1'b1;
        end else begin
            step_count <= step_count + 1'b1;
            step_tick  <= 1'b0;
        end
    end

    // strobes are single cycle
    // board and scanner act once per pulse
    scan_tick_single : assert property (
        @(posedge clk) disable iff (reset) scan_tick |=> !scan_tick
    );

    step_tick_single : assert property (
        @(posedge clk) disable iff (reset) step_tick |=> !step_tick
    );

endmodule

`default_nettype wire

// File: source/life_cell.sv
`default_nettype none

module life_cell #(
    // position of this cell on the board
    parameter int ROW = 0,
    parameter int COL = 0
) (
    input  life_pkg::board_t board,
    output logic             next_state
);

    // the eight neighbours, clockwise from top left
    logic [7:0]                neighbors;
    life_pkg::neighbor_count_t count;
    logic                      alive;

    // cell at (r, c), dead when off the board
    // no wrap at the edges
    function automatic logic cell_at(input life_pkg::board_t b, input int r, input int c);
        if (r < 0 || r > 7 || c < 0 || c > 7) begin
            return 1'b0;
        end
        return b[6'(r * 8 + c)];
    endfunction

    // row above
    assign neighbors[0] = cell_at(board, ROW - 1, COL - 1);
    assign neighbors[1] = cell_at(board, ROW - 1, COL);
    assign neighbors[2] = cell_at(board, ROW - 1, COL + 1);
    // same row
    assign neighbors[3] = cell_at(board, ROW, COL + 1);
    // row below
    assign neighbors[4] = cell_at(board, ROW + 1, COL + 1);
    assign neighbors[5] = cell_at(board, ROW + 1, COL);
    assign neighbors[6] = cell_at(board, ROW + 1, COL - 1);
    // same row, left side
    assign neighbors[7] = cell_at(board, ROW, COL - 1);

    // own state
    assign alive = cell_at(board, ROW, COL);

    // population count of the neighbours
    always_comb begin
        count = '0;
        for (int i = 0; i < 8; i++) begin
            count = count + life_pkg::neighbor_count_t'(neighbors[i]);
        end
    end

    // B3/S23
    // three neighbours always gives a live cell
    // two neighbours keeps a live cell alive
    assign next_state = (count == life_pkg::neighbor_count_t'(3))
                     || (alive && count == life_pkg::neighbor_count_t'(2));

endmodule

`default_nettype wire

// File: source/life_matrix.sv
`default_nettype none

module life_matrix #(
    // clock cycles per displayed row
    parameter int SCAN_CYCLES = 1000,
    // clock cycles per generation
    parameter int STEP_CYCLES = 1000000
) (
    input  logic                clk,
    input  logic                reset,
    // load an arbitrary seed, single cycle
    input  logic                seed_valid,
    input  life_pkg::board_t    seed,
    // led matrix drive
    output life_pkg::row_bits_t columns_out,
    output life_pkg::row_bits_t rows_out,
    // new generation marker
    output logic                step
);

    logic                 scan_tick;
    logic                 step_tick;
    life_pkg::board_t     board;
    life_pkg::board_t     next_board;
    scan_pkg::row_index_t row_index;
    scan_pkg::scan_slot_t slot;

    // strobe generation
    frame_timer #(
        .SCAN_CYCLES(SCAN_CYCLES),
        .STEP_CYCLES(STEP_CYCLES)
    ) u_timer (
        .clk      (clk),
        .reset    (reset),
        .scan_tick(scan_tick),
        .step_tick(step_tick)
    );

    // generation register
    board_state u_board (
        .clk       (clk),
        .reset     (reset),
        .seed_valid(seed_valid),
        .seed      (seed),
        .step_tick (step_tick),
        .next_board(next_board),
        .board     (board),
        .step      (step)
    );

    // cell array
    // each cell computes its own bit of the next board
    for (genvar r = 0; r < 8; r++) begin : g_row
        for (genvar c = 0; c < 8; c++) begin : g_col
            life_cell #(
                .ROW(r),
                .COL(c)
            ) u_cell (
                .board     (board),
                .next_state(next_board[8 * r + c])
            );
        end
    end

    // current row into the scan slot
    // row n starts at bit 8*n
    always_comb begin
        slot.index = row_index;
        slot.cells = board[{row_index, 3'b000} +: 8];
    end

    // row multiplexing onto the matrix
    matrix_scanner u_scanner (
        .clk        (clk),
        .reset      (reset),
        .scan_tick  (scan_tick),
        .slot       (slot),
        .row_index  (row_index),
        .columns_out(columns_out),
        .rows_out   (rows_out)
    );

endmodule

`default_nettype wire

// File: source/life_pkg.sv
`default_nettype none

package life_pkg;

    // whole board, one bit per cell
    // cell (row, col) sits at bit 8*row + col
    typedef logic [63:0] board_t;

    // one row of cells, bit n is column n
    typedef logic [7:0] row_bits_t;

    // live neighbours of one cell, 0 to 8
    typedef logic [3:0] neighbor_count_t;

    // octagon loaded at reset
    // listed from row 7 down to row 0
    localparam board_t default_seed = {
        // row 7
        8'b00011000,
        // row 6
        8'b00100100,
        // row 5
        8'b01000010,
        // row 4
        8'b10000001,
        // row 3
        8'b10000001,
        // row 2
        8'b01000010,
        // row 1
        8'b00100100,
        // row 0
        8'b00011000
    };

    // the shape is symmetric in both axes
    // so its bit order does not show on the matrix

endpackage

`default_nettype wire

// File: source/matrix_scanner.sv
`default_nettype none

module matrix_scanner (
    input  logic                  clk,
    input  logic                  reset,
    // advance to the next row
    input  logic                  scan_tick,
    // row chosen by the top level for row_index
    input  scan_pkg::scan_slot_t  slot,
    output scan_pkg::row_index_t  row_index,
    // one-hot and active high
    output life_pkg::row_bits_t   columns_out,
    // active low cell data
    output life_pkg::row_bits_t   rows_out
);

    // decoded column select for the slot
    life_pkg::row_bits_t column_select;

    // 3 to 8 decode of the slot's row
    assign column_select = life_pkg::row_bits_t'(1) << slot.index;

    // row counter
    // 3 bits so 7 rolls over to 0
    always_ff @(posedge clk) begin
        if (reset) begin
            row_index <= '0;
        end else if (scan_tick) begin
            row_index <= row_index + 1'b1;
        end
    end

    // matrix drivers
    // registered one cycle behind the slot
    // during reset all columns are off and all rows high
    // so every LED is dark
    always_ff @(posedge clk) begin
        if (reset) begin
            columns_out <= '0;
            rows_out    <= '1;
        end else begin
            columns_out <= column_select;
            // lit cell pulls its row line low
            rows_out    <= ~slot.cells;
        end
    end

    // exactly one column lit once out of reset
    columns_one_hot : assert property (
        @(posedge clk) disable iff (reset) !$past(reset) |-> $onehot(columns_out)
    );

endmodule

`default_nettype wire

// File: source/scan_pkg.sv
`default_nettype none

package scan_pkg;

    // number of the row being shown, 0 to 7
    typedef logic [2:0] row_index_t;

    // one scan slot
    // the row being shown plus the cells of that row
    typedef struct packed {
        // which row
        row_index_t          index;
        // its cells, bit n is column n
        life_pkg::row_bits_t cells;
    } scan_slot_t;

    // slot width is 3 + 8 bits
    // the scanner registers both halves in the same cycle

endpackage

`default_nettype wire

// File: verif/life_matrix_tb.sv
`default_nettype none

module life_matrix_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int scan_cycles = 2;
    localparam int step_cycles = 40;
    // a new row shows up every scan_cycles, plus slack
    localparam int slot_timeout = 2 * scan_cycles + 2;
    localparam int step_timeout = step_cycles + 8;

    // octagon, bytes are rows 7 down to 0, bit n of a row is column n
    localparam life_pkg::board_t octagon_seed = 64'h1824_4281_8142_2418;

    logic                clk = 1'b0;
    logic                reset;
    logic                seed_valid;
    life_pkg::board_t    seed;
    life_pkg::row_bits_t columns_out;
    life_pkg::row_bits_t rows_out;
    logic                step;

    logic [31:0]         rng_state;
    int                  failures = 0;
    // reset as seen by the last rising edge
    logic                reset_q;
    life_pkg::row_bits_t prev_cols;
    life_pkg::row_bits_t expected_cols;

    life_matrix #(
        .SCAN_CYCLES(scan_cycles),
        .STEP_CYCLES(step_cycles)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .seed_valid (seed_valid),
        .seed       (seed),
        .columns_out(columns_out),
        .rows_out   (rows_out),
        .step       (step)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        failures++;
        $display("[FAIL] %s expected %h actual %h", test, expected, actual);
        stop_run();
    endtask

    task automatic report_problem(input string what);
        failures++;
        $display("ERROR: %s", what);
        stop_run();
    endtask

    // 32-bit xorshift, shifts 13, 17, 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_word(output logic [63:0] word);
        rng_state = xorshift32(rng_state);
        word[63:32] = rng_state;
        rng_state = xorshift32(rng_state);
        word[31:0] = rng_state;
    endtask

    // reference B3/S23, everything off the board is dead
    function automatic life_pkg::board_t model_next(input life_pkg::board_t b);
        life_pkg::board_t n;
        int live;
        int r;
        int c;
        int dr;
        int dc;
        n = '0;
        for (r = 0; r < 8; r++) begin
            for (c = 0; c < 8; c++) begin
                live = 0;
                for (dr = -1; dr <= 1; dr++) begin
                    for (dc = -1; dc <= 1; dc++) begin
                        if ((dr != 0 || dc != 0) && r + dr >= 0 && r + dr < 8
                            && c + dc >= 0 && c + dc < 8) begin
                            live += int'(b[6'((r + dr) * 8 + c + dc)]);
                        end
                    end
                end
                n[6'(r * 8 + c)] = (live == 3) || (b[6'(r * 8 + c)] && live == 2);
            end
        end
        return n;
    endfunction

    function automatic life_pkg::row_bits_t rotate_up(input life_pkg::row_bits_t cols);
        return {cols[6:0], cols[7]};
    endfunction

    // returns on the falling edge where step is high
    task automatic wait_step(input string test);
        int waited;
        waited = 0;
        @(negedge clk);
        while (step !== 1'b1) begin
            waited++;
            if (waited > step_timeout) begin
                report_problem($sformatf("timeout waiting for a step pulse in %s", test));
            end
            @(negedge clk);
        end
    endtask

    // rebuild the board from the matrix, one slot per row
    task automatic capture_frame(input string test, output life_pkg::board_t frame);
        logic [7:0] seen;
        int         waited;
        int         slot;
        int         i;
        bit         got;
        seen = '0;
        frame = '0;
        for (slot = 0; slot < 8; slot++) begin
            got = 1'b0;
            waited = 0;
            while (!got) begin
                @(negedge clk);
                waited++;
                if (waited > slot_timeout) begin
                    report_problem($sformatf("timeout waiting for scan slot %0d in %s",
                                             slot, test));
                end
                for (i = 0; i < 8; i++) begin
                    if (columns_out == (8'h01 << i) && !seen[3'(i)]) begin
                        seen[3'(i)] = 1'b1;
                        // lit LED pulls its row line low
                        frame[6'(i * 8) +: 8] = ~rows_out;
                        got = 1'b1;
                    end
                end
            end
        end
    endtask

    // one-cycle strobe, optionally lined up with a step strobe
    task automatic load_seed(input life_pkg::board_t value, input bit on_step);
        @(negedge clk);
        if (on_step && UUT.step_tick !== 1'b1) begin
            report_problem("seed strobe did not line up with a step strobe");
        end
        seed = value;
        seed_valid = 1'b1;
        @(negedge clk);
        seed_valid = 1'b0;
    endtask

    task automatic check_seed_frame(input string test, input life_pkg::board_t expected);
        life_pkg::board_t got;
        capture_frame(test, got);
        assert (got == expected) else report_mismatch(test, expected, got);
    endtask

    task automatic run_generations(input string test, input life_pkg::board_t start,
                                   input int count);
        life_pkg::board_t prev;
        life_pkg::board_t expected;
        life_pkg::board_t got;
        int               g;
        prev = start;
        for (g = 1; g <= count; g++) begin
            wait_step(test);
            expected = model_next(prev);
            capture_frame(test, got);
            assert (got == expected)
                else report_mismatch($sformatf("%s gen %0d", test, g), expected, got);
            prev = got;
        end
    endtask

    always @(posedge clk) begin
        reset_q <= reset;
    end

    // matrix monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (reset_q === 1'b1) begin
            // dark during reset
            assert (columns_out == '0 && rows_out == '1)
                else report_mismatch("reset_dark", 64'(16'h00ff),
                                     64'({columns_out, rows_out}));
        end else if (reset_q === 1'b0 && columns_out != prev_cols) begin
            // row 0 first, then one row up per change
            expected_cols = (prev_cols == '0) ? 8'h01 : rotate_up(prev_cols);
            assert (columns_out == expected_cols)
                else report_mismatch("row_advance", 64'(expected_cols), 64'(columns_out));
        end
        prev_cols = columns_out;
    end

    columns_one_hot : assert property (
        @(posedge clk) disable iff (reset) !$past(reset) |-> $onehot(columns_out)
    ) else report_problem("columns_out is not one-hot outside reset");

    // a seed load replaces any step in the same cycle
    no_step_after_seed : assert property (
        @(posedge clk) disable iff (reset) seed_valid |=> !step
    ) else report_problem("step pulse given for a step strobe that a seed load replaced");

    initial begin
        life_pkg::board_t frame;
        logic [63:0]      word_a;
        logic [63:0]      word_b;
        int               i;
        reset = 1'b1;
        seed_valid = 1'b0;
        seed = '0;
        rng_state = 32'h46a23657;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // octagon shown before the first step
        check_seed_frame("reset_frame", octagon_seed);
        run_generations("octagon", octagon_seed, 5);

        // seed load right after a step
        wait_step("seed_load");
        draw_word(word_a);
        load_seed(word_a, 1'b0);
        check_seed_frame("seed_load", word_a);
        run_generations("seed_load", word_a, 2);

        // seed and step strobe in the same cycle
        wait_step("seed_vs_step");
        // next step strobe is step_cycles after the last one
        repeat (step_cycles - 2) @(negedge clk);
        draw_word(word_a);
        load_seed(word_a, 1'b1);
        check_seed_frame("seed_vs_step", word_a);
        run_generations("seed_vs_step", word_a, 1);

        // random seeds, odd ones sparse
        for (i = 0; i < 10; i++) begin
            wait_step($sformatf("random %0d", i));
            draw_word(word_a);
            if (i % 2 == 1) begin
                draw_word(word_b);
                word_a = word_a & word_b;
            end
            load_seed(word_a, 1'b0);
            check_seed_frame($sformatf("random %0d seed", i), word_a);
            run_generations($sformatf("random %0d", i), word_a, 3);
        end

        if (failures == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire
